// ==== rdma_pkg.sv ====
// Shared definitions for the RDMA send-queue front end.
// Field widths, RoCE opcode values and the packed structs for work
// requests, memory commands and decoded ACKs live here. Modules import
// this package inside their body and use scoped names in port lists.
`default_nettype none

package rdma_pkg;

  localparam int VADDR_BITS  = 48;
  localparam int LEN_BITS    = 28;
  localparam int PID_BITS    = 6;
  localparam int QPN_BITS    = 10;
  localparam int MSN_BITS    = 24;
  localparam int OPCODE_BITS = 5;
  localparam int SNDRM_BITS  = 8;

  // Raw ACK word, is_nak sits in bit 0
  localparam int ACK_PID_LSB   = 1;
  localparam int ACK_SNDRM_LSB = ACK_PID_LSB + PID_BITS;
  localparam int ACK_MSN_LSB   = ACK_SNDRM_LSB + SNDRM_BITS;
  localparam int ACK_RAW_BITS  = ACK_MSN_LSB + MSN_BITS;

  typedef logic [VADDR_BITS-1:0]  vaddr_t;
  typedef logic [LEN_BITS-1:0]    len_t;
  typedef logic [PID_BITS-1:0]    pid_t;
  typedef logic [QPN_BITS-1:0]    qpn_t;
  typedef logic [MSN_BITS-1:0]    msn_t;
  typedef logic [OPCODE_BITS-1:0] opcode_t;
  typedef logic [ACK_RAW_BITS-1:0] ack_raw_t;

  // RC opcodes as carried in the BTH
  localparam opcode_t RDMA_OP_SEND  = 5'h04;
  localparam opcode_t RDMA_OP_WRITE = 5'h0a;
  localparam opcode_t RDMA_OP_READ  = 5'h0c;

  typedef struct packed {
    opcode_t opcode;
    qpn_t    qpn;
    pid_t    pid;
    logic    host;
    vaddr_t  vaddr;
    len_t    len;
  } rdma_sq_req_t;

  typedef struct packed {
    vaddr_t vaddr;
    len_t   len;
    logic   host;
    pid_t   pid;
  } mem_req_t;

  typedef struct packed {
    logic                  is_nak;
    pid_t                  pid;
    logic [SNDRM_BITS-1:0] syndrome;
    msn_t                  msn;
  } rdma_ack_t;

endpackage

`default_nettype wire

// ==== sq_flow_ctrl.sv ====
// Admission control for the send queue.
// Counts requests in flight and closes both valid and ready of the
// queue once MAX_OUTSTANDING are outstanding. Each credit release from
// the ACK checker frees one slot again.
`default_nettype none

module sq_flow_ctrl #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  wire logic nclk,
  input  wire logic nresetn,
  input  wire logic sq_valid,
  input  wire logic fifo_ready,
  input  wire logic credit_release,
  output logic      sq_ready,
  output logic      fifo_valid
);

  logic [15:0] cnt_outstanding;
  logic        credit_ok;
  logic        accept;

  // Room for one more request in flight
  assign credit_ok = cnt_outstanding < 16'(MAX_OUTSTANDING);

  assign sq_ready   = fifo_ready & credit_ok;
  assign fifo_valid = sq_valid & credit_ok;
  assign accept     = sq_valid & sq_ready;

  // Accept and release may coincide and then cancel
  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      cnt_outstanding <= '0;
    end else begin
      case ({accept, credit_release})
        2'b10: begin
          cnt_outstanding <= cnt_outstanding + 16'd1;
        end
        2'b01: begin
          cnt_outstanding <= cnt_outstanding - 16'd1;
        end
        default: begin
          cnt_outstanding <= cnt_outstanding;
        end
      endcase
    end
  end

  // Requests still queued ahead of request generation count too
  a_cnt_limit: assert property (
    @(posedge nclk) disable iff (!nresetn)
    cnt_outstanding <= 16'(MAX_OUTSTANDING)
  );

  // Only credit taken by an earlier admission may come back
  a_cnt_no_wrap: assert property (
    @(posedge nclk) disable iff (!nresetn)
    credit_release && !accept |-> cnt_outstanding != '0
  );

endmodule

`default_nettype wire

// ==== sq_cmd_fifo.sv ====
// Short queue of admitted work requests.
// Entries are written into a register array and the head entry drives
// the output, so a request pushed on one edge is visible after it.
// in_ready drops while all FIFO_DEPTH slots are taken.
`default_nettype none

module sq_cmd_fifo #(
  parameter int FIFO_DEPTH = 2
) (
  input  wire logic                   nclk,
  input  wire logic                   nresetn,
  input  wire logic                   in_valid,
  input  wire rdma_pkg::rdma_sq_req_t in_req,
  input  wire logic                   out_ready,
  output logic                        in_ready,
  output logic                        out_valid,
  output rdma_pkg::rdma_sq_req_t      out_req
);
  import rdma_pkg::*;

  localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

  rdma_sq_req_t        mem [FIFO_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                full;
  logic                push;
  logic                pop;

  assign full      = count == CNT_BITS'(FIFO_DEPTH);
  assign in_ready  = !full;
  assign out_valid = count != '0;
  assign out_req   = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge nclk) begin
    if (push) begin
      mem[wr_ptr] <= in_req;
    end
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_BITS'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_BITS'(1);
      end
      // Occupancy
      case ({push, pop})
        2'b10: begin
          count <= count + CNT_BITS'(1);
        end
        2'b01: begin
          count <= count - CNT_BITS'(1);
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

  // A full queue has its write pointer back on the oldest entry
  a_no_push_full: assert property (
    @(posedge nclk) disable iff (!nresetn)
    full |-> wr_ptr == rd_ptr
  );

  // An empty queue has nothing between the read and write pointers
  a_no_pop_empty: assert property (
    @(posedge nclk) disable iff (!nresetn)
    !out_valid |-> wr_ptr == rd_ptr
  );

endmodule

`default_nettype wire

// ==== mem_req_gen.sv ====
// Memory command generation for admitted work requests.
// READ needs the local landing buffer written, so it becomes a write
// command. WRITE and SEND fetch local payload through a read command.
// A command is held until accepted, and nothing new is popped while a
// command would still be pending on the next edge.
`default_nettype none

module mem_req_gen (
  input  wire logic                   nclk,
  input  wire logic                   nresetn,
  input  wire logic                   cmd_valid,
  input  wire rdma_pkg::rdma_sq_req_t cmd,
  input  wire logic                   rd_req_ready,
  input  wire logic                   wr_req_ready,
  output logic                        cmd_ready,
  output logic                        rd_req_valid,
  output rdma_pkg::mem_req_t          rd_req,
  output logic                        wr_req_valid,
  output rdma_pkg::mem_req_t          wr_req
);
  import rdma_pkg::*;

  mem_req_t cmd_mem;
  logic     to_rd;
  logic     to_wr;
  logic     pop;

  // Same fields for both directions
  always_comb begin
    cmd_mem.vaddr = cmd.vaddr;
    cmd_mem.len   = cmd.len;
    cmd_mem.host  = cmd.host;
    cmd_mem.pid   = cmd.pid;
  end

  // Unknown opcodes match neither and are dropped on pop
  always_comb begin
    to_rd = 1'b0;
    to_wr = 1'b0;
    case (cmd.opcode)
      RDMA_OP_WRITE, RDMA_OP_SEND: begin
        to_rd = 1'b1;
      end
      RDMA_OP_READ: begin
        to_wr = 1'b1;
      end
      default: begin
        to_rd = 1'b0;
        to_wr = 1'b0;
      end
    endcase
  end

  assign cmd_ready = (!rd_req_valid || rd_req_ready) && (!wr_req_valid || wr_req_ready);
  assign pop       = cmd_valid & cmd_ready;

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      rd_req_valid <= 1'b0;
      wr_req_valid <= 1'b0;
    end else begin
      if (rd_req_ready) begin
        rd_req_valid <= 1'b0;
      end
      if (wr_req_ready) begin
        wr_req_valid <= 1'b0;
      end
      // New command wins over the acceptance of the old one
      if (pop && to_rd) begin
        rd_req_valid <= 1'b1;
      end
      if (pop && to_wr) begin
        wr_req_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge nclk) begin
    if (pop && to_rd) begin
      rd_req <= cmd_mem;
    end
    if (pop && to_wr) begin
      wr_req <= cmd_mem;
    end
  end

  a_rd_hold: assert property (
    @(posedge nclk) disable iff (!nresetn)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req)
  );

  a_wr_hold: assert property (
    @(posedge nclk) disable iff (!nresetn)
    wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req)
  );

endmodule

`default_nettype wire

// ==== ack_rx_check.sv ====
// ACK receive check.
// Unpacks the raw ACK word and compares its MSN with the next expected
// one. In-sequence ACKs and NAKs are reported one cycle later and free
// one credit. Out-of-sequence ones are dropped and counted, and the
// updated count is flagged with psn_drop_valid.
`default_nettype none

module ack_rx_check (
  input  wire logic             nclk,
  input  wire logic             nresetn,
  input  wire logic             ack_in_valid,
  input  wire rdma_pkg::ack_raw_t ack_in,
  output logic                  ack_valid,
  output rdma_pkg::rdma_ack_t   ack,
  output logic                  credit_release,
  output logic                  psn_drop_valid,
  output logic [31:0]           psn_drop_count
);
  import rdma_pkg::*;

  rdma_ack_t ack_dec;
  msn_t      exp_msn;
  logic      msn_match;

  // Raw word layout from bit 0 upwards
  always_comb begin
    ack_dec.is_nak   = ack_in[0];
    ack_dec.pid      = ack_in[ACK_PID_LSB +: PID_BITS];
    ack_dec.syndrome = ack_in[ACK_SNDRM_LSB +: SNDRM_BITS];
    ack_dec.msn      = ack_in[ACK_MSN_LSB +: MSN_BITS];
  end

  assign msn_match = ack_dec.msn == exp_msn;

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      ack_valid      <= 1'b0;
      psn_drop_valid <= 1'b0;
      psn_drop_count <= '0;
      exp_msn        <= '0;
    end else begin
      ack_valid      <= ack_in_valid & msn_match;
      psn_drop_valid <= ack_in_valid & !msn_match;
      if (ack_in_valid && msn_match) begin
        exp_msn <= exp_msn + msn_t'(1);
      end
      if (ack_in_valid && !msn_match) begin
        psn_drop_count <= psn_drop_count + 32'd1;
      end
    end
  end

  always_ff @(posedge nclk) begin
    if (ack_in_valid) begin
      ack <= ack_dec;
    end
  end

  // NAKs free their slot as well
  assign credit_release = ack_valid;

endmodule

`default_nettype wire

// ==== rdma_sq_top.sv ====
// Top level of the send-queue front end.
// Work requests pass admission control, wait in a short queue and are
// turned into memory read or write commands. Incoming ACKs are checked
// against the expected MSN and return credit to admission.
`default_nettype none

module rdma_sq_top #(
  parameter int MAX_OUTSTANDING = 4,
  parameter int FIFO_DEPTH      = 2
) (
  input  wire logic                   nclk,
  input  wire logic                   nresetn,
  input  wire logic                   sq_valid,
  input  wire rdma_pkg::rdma_sq_req_t sq_req,
  input  wire logic                   rd_req_ready,
  input  wire logic                   wr_req_ready,
  input  wire logic                   ack_in_valid,
  input  wire rdma_pkg::ack_raw_t     ack_in,
  output logic                        sq_ready,
  output logic                        rd_req_valid,
  output rdma_pkg::mem_req_t          rd_req,
  output logic                        wr_req_valid,
  output rdma_pkg::mem_req_t          wr_req,
  output logic                        ack_valid,
  output rdma_pkg::rdma_ack_t         ack,
  output logic                        psn_drop_valid,
  output logic [31:0]                 psn_drop_count
);
  import rdma_pkg::*;

  // Admission to queue
  logic         fifo_in_valid;
  logic         fifo_in_ready;

  // Queue to request generation
  logic         cmd_valid;
  logic         cmd_ready;
  rdma_sq_req_t cmd;

  logic         credit_release;

  sq_flow_ctrl #(
    .MAX_OUTSTANDING(MAX_OUTSTANDING)
  ) i_sq_flow_ctrl (
    .nclk           (nclk),
    .nresetn        (nresetn),
    .sq_valid       (sq_valid),
    .fifo_ready     (fifo_in_ready),
    .credit_release (credit_release),
    .sq_ready       (sq_ready),
    .fifo_valid     (fifo_in_valid)
  );

  sq_cmd_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_sq_cmd_fifo (
    .nclk      (nclk),
    .nresetn   (nresetn),
    .in_valid  (fifo_in_valid),
    .in_req    (sq_req),
    .out_ready (cmd_ready),
    .in_ready  (fifo_in_ready),
    .out_valid (cmd_valid),
    .out_req   (cmd)
  );

  mem_req_gen i_mem_req_gen (
    .nclk         (nclk),
    .nresetn      (nresetn),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .rd_req_ready (rd_req_ready),
    .wr_req_ready (wr_req_ready),
    .cmd_ready    (cmd_ready),
    .rd_req_valid (rd_req_valid),
    .rd_req       (rd_req),
    .wr_req_valid (wr_req_valid),
    .wr_req       (wr_req)
  );

  ack_rx_check i_ack_rx_check (
    .nclk           (nclk),
    .nresetn        (nresetn),
    .ack_in_valid   (ack_in_valid),
    .ack_in         (ack_in),
    .ack_valid      (ack_valid),
    .ack            (ack),
    .credit_release (credit_release),
    .psn_drop_valid (psn_drop_valid),
    .psn_drop_count (psn_drop_count)
  );

endmodule

`default_nettype wire

// ==== tb_rdma_sq.sv ====
// Testbench for the RDMA send-queue front end.
// Walks a table of work requests, raw ACKs and back-pressure phases
// through rdma_sq_top. Expected memory commands are queued per channel
// and matched in order by a monitor on the falling edge.
`default_nettype none

module tb_rdma_sq;
  timeunit 1ns;
  timeprecision 1ps;
  import rdma_pkg::*;

  localparam int MAX_OUTSTANDING = 4;
  localparam int FIFO_DEPTH      = 2;
  localparam int NUM_STEPS       = 22;
  localparam int BLOCK_WINDOW    = 20;
  localparam int HOLD_CYCLES     = 20;
  localparam int REQ_TIMEOUT     = 200;
  localparam int ACK_TIMEOUT     = 10;
  localparam int DRAIN_TIMEOUT   = 500;

  localparam logic [1:0] K_REQ     = 2'd0;
  localparam logic [1:0] K_ACK     = 2'd1;
  localparam logic [1:0] K_HOLD    = 2'd2;
  localparam logic [1:0] K_RELEASE = 2'd3;

  // One table row holding request or ACK fields by kind
  typedef struct packed {
    logic [1:0]   kind;
    logic         blocked;
    rdma_sq_req_t req;
    logic         is_nak;
    pid_t         pid;
    logic [7:0]   syndrome;
    msn_t         msn;
    logic         expect_report;
  } step_t;

  logic         nclk;
  logic         nresetn;
  logic         sq_valid;
  rdma_sq_req_t sq_req;
  logic         rd_req_ready;
  logic         wr_req_ready;
  logic         ack_in_valid;
  ack_raw_t     ack_in;
  logic         sq_ready;
  logic         rd_req_valid;
  mem_req_t     rd_req;
  logic         wr_req_valid;
  mem_req_t     wr_req;
  logic         ack_valid;
  rdma_ack_t    ack;
  logic         psn_drop_valid;
  logic [31:0]  psn_drop_count;

  step_t    steps [NUM_STEPS];
  mem_req_t exp_rd [$];
  mem_req_t exp_wr [$];
  logic     rd_hold;
  int       ack_seen;
  int       drop_seen;
  int       exp_reports;
  int       exp_drops;

  rdma_sq_top #(
    .MAX_OUTSTANDING(MAX_OUTSTANDING),
    .FIFO_DEPTH     (FIFO_DEPTH)
  ) i_rdma_sq_top (
    .nclk           (nclk),
    .nresetn        (nresetn),
    .sq_valid       (sq_valid),
    .sq_req         (sq_req),
    .rd_req_ready   (rd_req_ready),
    .wr_req_ready   (wr_req_ready),
    .ack_in_valid   (ack_in_valid),
    .ack_in         (ack_in),
    .sq_ready       (sq_ready),
    .rd_req_valid   (rd_req_valid),
    .rd_req         (rd_req),
    .wr_req_valid   (wr_req_valid),
    .wr_req         (wr_req),
    .ack_valid      (ack_valid),
    .ack            (ack),
    .psn_drop_valid (psn_drop_valid),
    .psn_drop_count (psn_drop_count)
  );

  initial begin
    nclk = 1'b0;
    forever #50 nclk = ~nclk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %s got=0x%0h exp=0x%0h", name, got, exp));
    end
  endtask

  function automatic step_t req_step(input opcode_t op, input pid_t pid, input logic host,
                                     input vaddr_t va, input len_t len, input logic blocked);
    step_t s;
    s = '0;
    s.kind       = K_REQ;
    s.blocked    = blocked;
    s.req.opcode = op;
    s.req.qpn    = 10'h05a;
    s.req.pid    = pid;
    s.req.host   = host;
    s.req.vaddr  = va;
    s.req.len    = len;
    return s;
  endfunction

  function automatic step_t ack_step(input logic is_nak, input pid_t pid, input logic [7:0] syn,
                                     input msn_t msn, input logic report);
    step_t s;
    s = '0;
    s.kind          = K_ACK;
    s.is_nak        = is_nak;
    s.pid           = pid;
    s.syndrome      = syn;
    s.msn           = msn;
    s.expect_report = report;
    return s;
  endfunction

  function automatic step_t control_step(input logic [1:0] kind);
    step_t s;
    s = '0;
    s.kind = kind;
    return s;
  endfunction

  // READ lands data locally, WRITE and SEND fetch payload
  function automatic mem_req_t expect_cmd(input rdma_sq_req_t r);
    mem_req_t m;
    m.vaddr = r.vaddr;
    m.len   = r.len;
    m.host  = r.host;
    m.pid   = r.pid;
    return m;
  endfunction

  task automatic fill_steps();
    // Fill the credit window, then one more that must wait
    steps[0]  = req_step(RDMA_OP_WRITE, 6'h01, 1'b1, 48'h0000_1000_0000, 28'h000_0400, 1'b0);
    steps[1]  = req_step(RDMA_OP_SEND,  6'h02, 1'b0, 48'h0000_2000_0040, 28'h000_0080, 1'b0);
    steps[2]  = req_step(RDMA_OP_READ,  6'h03, 1'b1, 48'h7fff_0000_1000, 28'h001_0000, 1'b0);
    steps[3]  = req_step(RDMA_OP_WRITE, 6'h04, 1'b0, 48'h0000_3000_0000, 28'h000_0010, 1'b0);
    steps[4]  = req_step(RDMA_OP_SEND,  6'h05, 1'b1, 48'h0000_4000_0000, 28'h000_0020, 1'b1);
    steps[5]  = ack_step(1'b0, 6'h01, 8'h00, 24'd0, 1'b1);
    steps[6]  = req_step(RDMA_OP_SEND,  6'h06, 1'b0, 48'h0000_5000_0100, 28'h000_0200, 1'b0);
    steps[7]  = req_step(RDMA_OP_READ,  6'h07, 1'b1, 48'h0000_6000_0000, 28'h000_0800, 1'b1);
    steps[8]  = ack_step(1'b1, 6'h02, 8'h61, 24'd1, 1'b1);
    steps[9]  = req_step(RDMA_OP_READ,  6'h08, 1'b1, 48'h0abc_0000_2000, 28'h0ff_ffff, 1'b0);
    // Out-of-sequence MSN, then the real one
    steps[10] = ack_step(1'b0, 6'h03, 8'h00, 24'd5, 1'b0);
    steps[11] = req_step(RDMA_OP_WRITE, 6'h09, 1'b0, 48'h0000_7000_0000, 28'h000_0004, 1'b1);
    steps[12] = ack_step(1'b0, 6'h03, 8'h00, 24'd2, 1'b1);
    steps[13] = ack_step(1'b0, 6'h04, 8'h1f, 24'd3, 1'b1);
    steps[14] = ack_step(1'b1, 6'h06, 8'h80, 24'd4, 1'b1);
    steps[15] = ack_step(1'b0, 6'h08, 8'h00, 24'd5, 1'b1);
    // Read channel stalled while commands pile up
    steps[16] = control_step(K_HOLD);
    steps[17] = req_step(RDMA_OP_WRITE, 6'h0a, 1'b1, 48'h0000_8000_0000, 28'h000_1000, 1'b0);
    steps[18] = req_step(RDMA_OP_SEND,  6'h0b, 1'b0, 48'h0000_9000_0000, 28'h000_0040, 1'b0);
    steps[19] = req_step(RDMA_OP_WRITE, 6'h0c, 1'b1, 48'h0000_a000_0000, 28'h000_0100, 1'b0);
    steps[20] = control_step(K_RELEASE);
    steps[21] = req_step(RDMA_OP_READ,  6'h0d, 1'b0, 48'h0000_b000_0000, 28'h000_2000, 1'b0);
  endtask

  task automatic post_req(input step_t s);
    int   waited;
    int   limit;
    logic taken;
    limit  = s.blocked ? BLOCK_WINDOW : REQ_TIMEOUT;
    taken  = 1'b0;
    waited = 0;
    @(posedge nclk);
    sq_valid <= 1'b1;
    sq_req   <= s.req;
    while (!taken && waited < limit) begin
      @(negedge nclk);
      taken = sq_ready;
      @(posedge nclk);
      waited++;
    end
    sq_valid <= 1'b0;
    if (s.blocked) begin
      check("sq_ready", 128'(taken), 128'(1'b0));
    end else if (!taken) begin
      stop_run("work request was not accepted before the timeout");
    end else if (s.req.opcode == RDMA_OP_READ) begin
      exp_wr.push_back(expect_cmd(s.req));
    end else begin
      exp_rd.push_back(expect_cmd(s.req));
    end
  endtask

  task automatic send_ack(input step_t s);
    int   waited;
    logic seen;
    seen   = 1'b0;
    waited = 0;
    @(posedge nclk);
    ack_in_valid <= 1'b1;
    ack_in       <= {s.msn, s.syndrome, s.pid, s.is_nak};
    @(posedge nclk);
    ack_in_valid <= 1'b0;
    while (!seen && waited < ACK_TIMEOUT) begin
      @(negedge nclk);
      seen = ack_valid || psn_drop_valid;
      waited++;
    end
    if (!seen) begin
      stop_run("ACK input produced neither a report nor a drop");
    end
    check("ack_valid", 128'(ack_valid), 128'(s.expect_report));
    check("psn_drop_valid", 128'(psn_drop_valid), 128'(!s.expect_report));
    if (s.expect_report) begin
      exp_reports++;
      check("ack.is_nak", 128'(ack.is_nak), 128'(s.is_nak));
      check("ack.pid", 128'(ack.pid), 128'(s.pid));
      check("ack.syndrome", 128'(ack.syndrome), 128'(s.syndrome));
      check("ack.msn", 128'(ack.msn), 128'(s.msn));
    end else begin
      exp_drops++;
      check("psn_drop_count", 128'(psn_drop_count), 128'(exp_drops));
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while ((exp_rd.size() != 0 || exp_wr.size() != 0) && waited < DRAIN_TIMEOUT) begin
      @(negedge nclk);
      waited++;
    end
    if (exp_rd.size() != 0 || exp_wr.size() != 0) begin
      stop_run("memory commands still missing after the drain timeout");
    end
  endtask

  // Sink readiness with the read side forced low during a hold
  initial begin : ready_gen
    integer seed;
    integer rnd;
    seed = 32'h27974668;
    rd_req_ready = 1'b0;
    wr_req_ready = 1'b0;
    forever begin
      @(posedge nclk);
      rnd = $random(seed);
      rd_req_ready <= rd_hold ? 1'b0 : rnd[0];
      wr_req_ready <= rnd[1];
    end
  end

  // Order, stability under stall, pulse counts
  initial begin : monitor
    mem_req_t want;
    mem_req_t rd_last;
    mem_req_t wr_last;
    logic     rd_stall;
    logic     wr_stall;
    rd_stall = 1'b0;
    wr_stall = 1'b0;
    forever begin
      @(negedge nclk);
      if (rd_stall) begin
        check("rd_req_valid", 128'(rd_req_valid), 128'(1'b1));
        check("rd_req", 128'(rd_req), 128'(rd_last));
      end
      if (wr_stall) begin
        check("wr_req_valid", 128'(wr_req_valid), 128'(1'b1));
        check("wr_req", 128'(wr_req), 128'(wr_last));
      end
      if (rd_req_valid && rd_req_ready) begin
        if (exp_rd.size() == 0) begin
          stop_run("rd_req issued without a matching work request");
        end else begin
          want = exp_rd.pop_front();
          check("rd_req", 128'(rd_req), 128'(want));
        end
      end
      if (wr_req_valid && wr_req_ready) begin
        if (exp_wr.size() == 0) begin
          stop_run("wr_req issued without a matching work request");
        end else begin
          want = exp_wr.pop_front();
          check("wr_req", 128'(wr_req), 128'(want));
        end
      end
      rd_stall = rd_req_valid && !rd_req_ready;
      wr_stall = wr_req_valid && !wr_req_ready;
      rd_last  = rd_req;
      wr_last  = wr_req;
      if (ack_valid) ack_seen++;
      if (psn_drop_valid) drop_seen++;
    end
  end

  initial begin
    nresetn      = 1'b0;
    sq_valid     = 1'b0;
    sq_req       = '0;
    ack_in_valid = 1'b0;
    ack_in       = '0;
    rd_hold      = 1'b0;
    ack_seen     = 0;
    drop_seen    = 0;
    exp_reports  = 0;
    exp_drops    = 0;
    fill_steps();
    repeat (3) @(posedge nclk);
    nresetn <= 1'b1;
    @(negedge nclk);
    // Empty queue and no credit in use
    check("sq_ready", 128'(sq_ready), 128'(1'b1));
    check("rd_req_valid", 128'(rd_req_valid), 128'(1'b0));
    check("wr_req_valid", 128'(wr_req_valid), 128'(1'b0));
    check("ack_valid", 128'(ack_valid), 128'(1'b0));
    check("psn_drop_valid", 128'(psn_drop_valid), 128'(1'b0));
    check("psn_drop_count", 128'(psn_drop_count), 128'(32'd0));
    for (int i = 0; i < NUM_STEPS; i++) begin
      case (steps[i].kind)
        K_REQ: begin
          post_req(steps[i]);
        end
        K_ACK: begin
          send_ack(steps[i]);
        end
        K_HOLD: begin
          @(negedge nclk);
          rd_hold = 1'b1;
        end
        default: begin
          repeat (HOLD_CYCLES) @(posedge nclk);
          @(negedge nclk);
          check("rd_req_valid", 128'(rd_req_valid), 128'(1'b1));
          rd_hold = 1'b0;
        end
      endcase
    end
    wait_drained();
    // Quiet window to catch stray commands or pulses
    repeat (BLOCK_WINDOW) @(negedge nclk);
    check("ack_valid pulses", 128'(ack_seen), 128'(exp_reports));
    check("psn_drop_valid pulses", 128'(drop_seen), 128'(exp_drops));
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
rdma_pkg.sv
sq_flow_ctrl.sv
sq_cmd_fifo.sv
mem_req_gen.sv
ack_rx_check.sv
rdma_sq_top.sv
tb_rdma_sq.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rdma_sq
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
